/* verilog/lsi_bus_pkg.sv */
// lsi bus package: extended microcode codes and the widths of the bus glue
package lsi_bus_pkg;

   // field and word widths
   localparam int MC_W   = 4;        // extended microcode field M18-M21
   localparam int DAT_W  = 16;       // address/data word of the data chip
   localparam int QTIM_W = 6;        // q-bus timer, times out at all ones
   localparam int WCNT_W = 8;        // slow clock wait counter, saturating

   // extended microcode codes, as seen on M21..M18
   localparam logic [MC_W-1:0] MC_CLR_INIT = 4'b1001;   // code 011, deassert INIT
   localparam logic [MC_W-1:0] MC_CLR_BERR = 4'b1010;   // code 012, clear bus error
   localparam logic [MC_W-1:0] MC_SET_INIT = 4'b1100;   // code 014, assert INIT
   localparam logic [MC_W-1:0] MC_SET_FDIN = 4'b1101;   // code 015, fast input flag
   localparam logic [MC_W-1:0] MC_CLR_ACLO = 4'b1110;   // code 016, drop power fail rq
   localparam logic [MC_W-1:0] MC_CLR_EVNT = 4'b1111;   // code 017, drop timer rq

   // codes 010, 013 and the lower half mean nothing to this glue

endpackage

/* verilog/lsi_wb_master.sv */
// wishbone master and vector fetch sequencer for the lsi-11 chipset strobes
`timescale 1ns/1ps

module lsi_wb_master
   import lsi_bus_pkg::*;
(
   input  logic             vm_clk_p,     // core clock
   input  logic             m_sr,         // system reset, async, high
                                          //
   input  logic             m_syns_i,     // sync set, opens the cycle
   input  logic             m_synr_i,     // sync reset, ends a read cycle
   input  logic             m_dclr_i,     // read data taken by chip
   input  logic             m_di_i,       // data input request
   input  logic             m_do_i,       // data output request
   input  logic             m_iak_i,      // interrupt ack, vector fetch
   input  logic             m_wrby_i,     // byte write
   input  logic             m_astb_i,     // address strobe from data chip
   input  logic             m_dstb_i,     // data strobe from data chip
   input  logic [DAT_W-1:0] m_ado_i,      // data chip output word
                                          //
   input  logic [DAT_W-1:0] wbm_dat_i,    // master read data
   input  logic             wbm_ack_i,    // master ack
   input  logic [DAT_W-1:0] wbi_dat_i,    // vector data
   input  logic             wbi_ack_i,    // vector ack
                                          //
   input  logic             fdin_st_i,    // fast input overlay active
   input  logic [3:0]       fdin_nib_i,   // overlay nibble
                                          //
   output logic [DAT_W-1:0] wbm_adr_o,    // address latch
   output logic [DAT_W-1:0] wbm_dat_o,    // write data latch
   output logic             wbm_cyc_o,    // bus cycle
   output logic             wbm_we_o,     // write direction
   output logic [1:0]       wbm_sel_o,    // byte lanes
   output logic             wbm_stb_o,    // master strobe
   output logic             wbi_stb_o,    // vector strobe
   output logic [DAT_W-1:0] m_adi_o,      // data chip input word
   output logic             m_ra_o        // reply to control chip
);

   logic       wr_done;                   // write acked
   logic       rd_done;                   // read acked
   logic       iv_done;                   // vector acked
   logic       wr_start;                  // launch write strobe
   logic       rd_start;                  // launch read strobe
   logic       iv_start;                  // launch vector strobe
   logic       rd_rdy;                    // data waits for the chip
   logic [1:0] ra_q;                      // two stage reply

   assign wr_done  = wbm_stb_o & wbm_ack_i & wbm_we_o;
   assign rd_done  = wbm_stb_o & wbm_ack_i & ~wbm_we_o;
   assign iv_done  = wbi_stb_o & wbi_ack_i;

   // chip holds its request levels until the reply, so launch only once
   assign wr_start = m_do_i & wbm_cyc_o & ~wbm_stb_o;
   assign rd_start = m_di_i & ~wbm_stb_o & ~rd_rdy;
   assign iv_start = m_iak_i & ~wbi_stb_o & ~rd_rdy;

   // address and data latches follow the data chip strobes
   always_ff @(posedge vm_clk_p)
   begin
      if (m_astb_i)
         wbm_adr_o <= m_ado_i;
      if (m_dstb_i)
         wbm_dat_o <= m_ado_i;
   end

   // captured read word, overlay on the low nibble for unaddressed input
   always_ff @(posedge vm_clk_p)
   begin
      if (rd_done)
         m_adi_o <= fdin_st_i ? {wbm_dat_i[DAT_W-1:4], fdin_nib_i} : wbm_dat_i;
      else if (iv_done)
         m_adi_o <= wbi_dat_i;            // interrupt vector
   end

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
      begin
         wbm_cyc_o <= 1'b0;
         wbm_stb_o <= 1'b0;
         wbm_we_o  <= 1'b0;
         wbm_sel_o <= 2'b11;
         wbi_stb_o <= 1'b0;
         rd_rdy    <= 1'b0;
         ra_q      <= 2'b00;
      end
      else
      begin
         // write ends at its ack, read waits for sync reset
         if (wr_done | m_synr_i & (rd_done | rd_rdy))
            wbm_cyc_o <= 1'b0;
         else if (m_syns_i)
            wbm_cyc_o <= 1'b1;

         // master strobe holds until acked, no limit of its own
         if (wr_start | rd_start)
            wbm_stb_o <= 1'b1;
         else if (wr_done | rd_done)
            wbm_stb_o <= 1'b0;

         if (wr_start)
            wbm_we_o <= 1'b1;
         else if (wr_done)
            wbm_we_o <= 1'b0;

         // byte lane by address bit 0, word otherwise
         if (wr_start)
         begin
            if (m_wrby_i)
               wbm_sel_o <= wbm_adr_o[0] ? 2'b10 : 2'b01;
            else
               wbm_sel_o <= 2'b11;
         end
         else if (wr_done)
            wbm_sel_o <= 2'b11;

         if (iv_start)
            wbi_stb_o <= 1'b1;
         else if (iv_done)
            wbi_stb_o <= 1'b0;

         // data ready until the chip moves on
         if (m_syns_i | m_synr_i | m_dclr_i)
            rd_rdy <= 1'b0;
         else if (rd_done | iv_done)
            rd_rdy <= 1'b1;

         // reply pulse, second stage cut by synr or dclr
         ra_q[0] <= wr_done | rd_done | iv_done;
         ra_q[1] <= ra_q[0] & ~(m_synr_i | m_dclr_i);
      end
   end

   assign m_ra_o = ra_q[0] | ra_q[1];

endmodule

/* verilog/lsi_bus_moderator.sv */
// bus moderator: holds the control chip with bus busy in slow clock mode
`timescale 1ns/1ps

module lsi_bus_moderator
   import lsi_bus_pkg::*;
(
   input  logic vm_clk_p,                 // core clock
   input  logic m_sr,                     // system reset, async, high
   input  logic vm_clk_ena_i,             // slow clock enable
   input  logic vm_clk_slow_i,            // slow clock mode
   input  logic m_breq_i,                 // bus request from control chip
   output logic m_bbusy_o                 // bus busy to control chip
);

   localparam logic [WCNT_W-1:0] WCNT_MAX = {WCNT_W{1'b1}};
   localparam logic [WCNT_W-1:0] WCNT_ONE = {{(WCNT_W-1){1'b0}}, 1'b1};

   logic [WCNT_W-1:0] wcnt;               // enables owed to the slow clock
   logic              bb_set;             // debt pending, no request
   logic              bb_clr;             // debt paid or mode off

   assign bb_set = vm_clk_slow_i & ~m_breq_i & (wcnt != '0);
   assign bb_clr = ~vm_clk_slow_i | (vm_clk_ena_i & (wcnt == WCNT_ONE));

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         m_bbusy_o <= 1'b0;
      else if (bb_set)
         m_bbusy_o <= 1'b1;
      else if (bb_clr)
         m_bbusy_o <= 1'b0;
   end

   // pay back on enables while held, else count skipped clocks
   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         wcnt <= '0;
      else if (m_bbusy_o & m_breq_i)
      begin
         if (vm_clk_ena_i)
            wcnt <= wcnt - WCNT_ONE;
      end
      else if (~vm_clk_ena_i & vm_clk_slow_i & (wcnt != WCNT_MAX))
         wcnt <= wcnt + WCNT_ONE;         // saturates at all ones
   end

endmodule

/* verilog/lsi_sys_ctl.sv */
// system control with extended code strobes, interrupt requests, INIT and q-bus timeout
`timescale 1ns/1ps

module lsi_sys_ctl
   import lsi_bus_pkg::*;
(
   input  logic            vm_clk_p,      // core clock
   input  logic            vm_dclo_i,     // dc power low resets the processor
   input  logic            vm_aclo_i,     // ac power fail
   input  logic            vm_halt_i,     // halt mode request
   input  logic            vm_evnt_i,     // timer event
   input  logic            vm_virq_i,     // vectored interrupt request
   input  logic [1:0]      vm_bsel_i,     // boot mode select
   input  logic [MC_W-1:0] m_mcode_i,     // extended microcode M21..M18
   input  logic            wbm_gnt_i,     // bus granted
   input  logic            wbm_cyc_i,     // master cycle
   input  logic            wbm_stb_i,     // master strobe
   input  logic            wbi_stb_i,     // vector strobe
   output logic            m_sr_o,        // system reset
   output logic            vm_init_o,     // peripheral INIT
   output logic [3:1]      m_inrrq_o,     // interrupt requests
   output logic            fdin_st_o,     // fast input overlay flag
   output logic [3:0]      fdin_nib_o     // fast input nibble
);

   logic              mc_clr_init;        // code 011
   logic              mc_clr_berr;        // code 012
   logic              mc_set_init;        // code 014
   logic              mc_set_fdin;        // code 015
   logic              mc_clr_aclo;        // code 016
   logic              mc_clr_evnt;        // code 017

   // request, flag and timer state
   logic              aclo_ed  = 1'b0;    // aclo edge detector
   logic              evnt_ed  = 1'b0;    // evnt edge detector
   logic              wcyc_ed  = 1'b0;    // cycle edge detector
   logic              aclo_rq  = 1'b0;    // power fail pending
   logic              evnt_rq  = 1'b0;    // timer pending
   logic              init_st  = 1'b1;    // INIT flag
   logic              fdin_st  = 1'b0;    // overlay flag
   logic              berr_st  = 1'b0;    // sticky bus error
   logic              berr_rq  = 1'b0;    // timeout abort request
   logic              sr_q     = 1'b1;    // system reset register
   logic [QTIM_W-1:0] qtim     = '0;      // q-bus transaction timer
   logic              qtim_to;            // timer at all ones
   logic              qtim_en;            // strobe out with grant

   assign mc_clr_init = (m_mcode_i == MC_CLR_INIT);
   assign mc_clr_berr = (m_mcode_i == MC_CLR_BERR);
   assign mc_set_init = (m_mcode_i == MC_SET_INIT);
   assign mc_set_fdin = (m_mcode_i == MC_SET_FDIN);
   assign mc_clr_aclo = (m_mcode_i == MC_CLR_ACLO);
   assign mc_clr_evnt = (m_mcode_i == MC_CLR_EVNT);

   // power fail and timer rising edges
   always_ff @(posedge vm_clk_p)
   begin
      aclo_ed <= vm_aclo_i;
      evnt_ed <= vm_evnt_i;
      if (mc_clr_aclo | vm_dclo_i)
         aclo_rq <= 1'b0;
      else if (vm_aclo_i & ~aclo_ed)
         aclo_rq <= 1'b1;
      if (mc_clr_evnt | vm_dclo_i)
         evnt_rq <= 1'b0;
      else if (vm_evnt_i & ~evnt_ed)
         evnt_rq <= 1'b1;
   end

   // INIT follows dclo and microcode
   always_ff @(posedge vm_clk_p)
   begin
      if (vm_dclo_i | mc_set_init)
         init_st <= 1'b1;
      else if (mc_clr_init)
         init_st <= 1'b0;
   end

   // overlay lives for one bus cycle
   always_ff @(posedge vm_clk_p)
   begin
      wcyc_ed <= wbm_cyc_i;
      if (~wbm_cyc_i & wcyc_ed)
         fdin_st <= 1'b0;                 // cycle just ended
      else if (mc_set_fdin & wbm_cyc_i)
         fdin_st <= 1'b1;
   end

   assign qtim_en = wbm_gnt_i & (wbm_stb_i | wbi_stb_i);
   assign qtim_to = &qtim;

   // q-bus timer, bus error and abort
   always_ff @(posedge vm_clk_p)
   begin
      if (~qtim_en)
         qtim <= '0;
      else if (~qtim_to)
         qtim <= qtim + 1'b1;
      if (init_st | mc_clr_berr)
         berr_st <= 1'b0;
      else if (qtim_to)
         berr_st <= 1'b1;
      berr_rq <= qtim_en & qtim_to;
      sr_q    <= vm_dclo_i | berr_rq;     // abort via system reset
   end

   assign m_sr_o       = sr_q;
   assign vm_init_o    = init_st;
   assign m_inrrq_o[1] = vm_virq_i;
   assign m_inrrq_o[2] = evnt_rq;
   assign m_inrrq_o[3] = aclo_rq | vm_halt_i;
   assign fdin_st_o    = fdin_st;
   assign fdin_nib_o   = {vm_aclo_i | aclo_rq, berr_st, vm_bsel_i};

endmodule

/* verilog/lsi_wb.sv */
// lsi-11 bus glue top: wishbone master, bus moderator and system control
`timescale 1ns/1ps

module lsi_wb
   import lsi_bus_pkg::*;
(
   input  logic             vm_clk_p,     // core clock
   input  logic             vm_dclo_i,    // processor reset
   input  logic             vm_aclo_i,    // power fail
   input  logic             vm_halt_i,    // halt request
   input  logic             vm_evnt_i,    // timer event
   input  logic             vm_virq_i,    // vectored irq
   input  logic             vm_clk_ena_i, // slow clock enable
   input  logic             vm_clk_slow_i,// slow clock mode
   input  logic [1:0]       vm_bsel_i,    // boot mode
   input  logic             m_syns_i,     // control chip strobes
   input  logic             m_synr_i,
   input  logic             m_dclr_i,
   input  logic             m_di_i,
   input  logic             m_do_i,
   input  logic             m_iak_i,
   input  logic             m_wrby_i,
   input  logic             m_breq_i,
   input  logic             m_astb_i,     // data chip strobes
   input  logic             m_dstb_i,
   input  logic [DAT_W-1:0] m_ado_i,      // data chip word out
   input  logic [MC_W-1:0]  m_mcode_i,    // extended microcode
   input  logic             wbm_gnt_i,
   input  logic [DAT_W-1:0] wbm_dat_i,
   input  logic             wbm_ack_i,
   input  logic [DAT_W-1:0] wbi_dat_i,
   input  logic             wbi_ack_i,
   output logic             vm_init_o,
   output logic             m_sr_o,
   output logic [DAT_W-1:0] m_adi_o,
   output logic             m_ra_o,
   output logic             m_bbusy_o,
   output logic [3:1]       m_inrrq_o,
   output logic [DAT_W-1:0] wbm_adr_o,
   output logic [DAT_W-1:0] wbm_dat_o,
   output logic             wbm_cyc_o,
   output logic             wbm_we_o,
   output logic [1:0]       wbm_sel_o,
   output logic             wbm_stb_o,
   output logic             wbi_stb_o
);

   logic       fdin_st;                   // overlay flag to master
   logic [3:0] fdin_nib;                  // overlay nibble to master

   lsi_sys_ctl sys_ctl (
      .vm_clk_p  (vm_clk_p),   .vm_dclo_i (vm_dclo_i),  .vm_aclo_i (vm_aclo_i),
      .vm_halt_i (vm_halt_i),  .vm_evnt_i (vm_evnt_i),  .vm_virq_i (vm_virq_i),
      .vm_bsel_i (vm_bsel_i),  .m_mcode_i (m_mcode_i),  .wbm_gnt_i (wbm_gnt_i),
      .wbm_cyc_i (wbm_cyc_o),  .wbm_stb_i (wbm_stb_o),  .wbi_stb_i (wbi_stb_o),
      .m_sr_o    (m_sr_o),     .vm_init_o (vm_init_o),  .m_inrrq_o (m_inrrq_o),
      .fdin_st_o (fdin_st),    .fdin_nib_o(fdin_nib)
   );

   lsi_wb_master master (
      .vm_clk_p  (vm_clk_p),   .m_sr      (m_sr_o),     .m_syns_i  (m_syns_i),
      .m_synr_i  (m_synr_i),   .m_dclr_i  (m_dclr_i),   .m_di_i    (m_di_i),
      .m_do_i    (m_do_i),     .m_iak_i   (m_iak_i),    .m_wrby_i  (m_wrby_i),
      .m_astb_i  (m_astb_i),   .m_dstb_i  (m_dstb_i),   .m_ado_i   (m_ado_i),
      .wbm_dat_i (wbm_dat_i),  .wbm_ack_i (wbm_ack_i),  .wbi_dat_i (wbi_dat_i),
      .wbi_ack_i (wbi_ack_i),  .fdin_st_i (fdin_st),    .fdin_nib_i(fdin_nib),
      .wbm_adr_o (wbm_adr_o),  .wbm_dat_o (wbm_dat_o),  .wbm_cyc_o (wbm_cyc_o),
      .wbm_we_o  (wbm_we_o),   .wbm_sel_o (wbm_sel_o),  .wbm_stb_o (wbm_stb_o),
      .wbi_stb_o (wbi_stb_o),  .m_adi_o   (m_adi_o),    .m_ra_o    (m_ra_o)
   );

   lsi_bus_moderator moderator (
      .vm_clk_p     (vm_clk_p),
      .m_sr         (m_sr_o),             // same abort as the master
      .vm_clk_ena_i (vm_clk_ena_i),
      .vm_clk_slow_i(vm_clk_slow_i),
      .m_breq_i     (m_breq_i),
      .m_bbusy_o    (m_bbusy_o)
   );

endmodule

/* test/lsi_wb_assert.sv */
// bound property checks on the lsi-11 bus glue strobes and reply
`timescale 1ns/1ps

module lsi_wb_assert
(
   input logic vm_clk_p,                  // core clock
   input logic m_sr_i,                    // system reset
   input logic wbm_stb_i,                 // master strobe
   input logic wbm_we_i,                  // master write
   input logic wbm_ack_i,                 // master ack
   input logic wbi_stb_i,                 // vector strobe
   input logic wbi_ack_i,                 // vector ack
   input logic m_ra_i                     // reply to control chip
);

   logic ack_seen;                        // some strobe acked this cycle

   assign ack_seen = wbm_stb_i & wbm_ack_i | wbi_stb_i & wbi_ack_i;

   sr_quiet: assert property (@(posedge vm_clk_p)
      m_sr_i && $past(m_sr_i) |-> !wbm_stb_i && !wbi_stb_i && !m_ra_i)
      else $error("strobe or reply active while system reset is held");

   we_in_stb: assert property (@(posedge vm_clk_p) wbm_we_i |-> wbm_stb_i)
      else $error("write direction without master strobe");

   // reply needs an ack one or two cycles back
   ra_after_ack: assert property (@(posedge vm_clk_p)
      $rose(m_ra_i) |-> $past(ack_seen) || $past(ack_seen, 2))
      else $error("reply rose with no recent ack");

   stb_hold: assert property (@(posedge vm_clk_p) disable iff (m_sr_i)
      wbm_stb_i && !wbm_ack_i |=> wbm_stb_i)
      else $error("master strobe dropped without ack or reset");

endmodule

bind lsi_wb lsi_wb_assert bus_checks (
   .vm_clk_p (vm_clk_p),  .m_sr_i    (m_sr_o),     .wbm_stb_i (wbm_stb_o),
   .wbm_we_i (wbm_we_o),  .wbm_ack_i (wbm_ack_i),  .wbi_stb_i (wbi_stb_o),
   .wbi_ack_i(wbi_ack_i), .m_ra_i    (m_ra_o)
);

/* test/tb_lsi_wb.sv */
// testbench for the lsi-11 bus glue that plays the chipset and both wishbone slaves
`timescale 1ns/1ps

module tb_lsi_wb
   import lsi_bus_pkg::*;
();

   logic             vm_clk_p;
   logic             vm_dclo_i, vm_aclo_i, vm_halt_i, vm_evnt_i, vm_virq_i;  // system levels
   logic             vm_clk_ena_i, vm_clk_slow_i, m_breq_i;                  // moderator side
   logic [1:0]       vm_bsel_i;
   logic             m_syns_i, m_synr_i, m_dclr_i, m_di_i, m_do_i, m_iak_i, m_wrby_i;
   logic             m_astb_i, m_dstb_i;                                     // data chip strobes
   logic [DAT_W-1:0] m_ado_i;
   logic [MC_W-1:0]  m_mcode_i;
   logic             wbm_gnt_i, wbm_ack_i, wbi_ack_i;
   logic [DAT_W-1:0] wbm_dat_i, wbi_dat_i;
   logic             vm_init_o, m_sr_o, m_ra_o, m_bbusy_o;
   logic [DAT_W-1:0] m_adi_o, wbm_adr_o, wbm_dat_o;
   logic [3:1]       m_inrrq_o;
   logic             wbm_cyc_o, wbm_we_o, wbm_stb_o, wbi_stb_o;
   logic [1:0]       wbm_sel_o;
   int               errors = 0;
   int               checks = 0;
   logic [31:0]      lcg_state = 32'd92027;                                  // rng seed

   lsi_wb UUT (.*);

   initial
   begin
      vm_clk_p = 1'b0;
      forever #20 vm_clk_p = ~vm_clk_p;   // 40 ns period
   end

   function automatic logic [DAT_W-1:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];            // upper half of the lcg state
   endfunction

   function automatic logic probe(input string sig);   // dut level by name
      if (sig == "wbm_stb_o")
         return wbm_stb_o;
      else if (sig == "wbi_stb_o")
         return wbi_stb_o;
      else if (sig == "m_ra_o")
         return m_ra_o;
      else if (sig == "m_sr_o")
         return m_sr_o;
      return m_bbusy_o;
   endfunction

   task automatic check_word(input string name, input logic [DAT_W-1:0] exp,
                             input logic [DAT_W-1:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_sel(input string name, input logic [1:0] exp, input logic [1:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic wait_for(input string sig, input logic val, input int limit);
      int n;
      n = 0;
      while (probe(sig) !== val && n < limit)
      begin
         @(negedge vm_clk_p);
         n++;
      end
      if (probe(sig) !== val)
      begin
         errors++;
         $display("TIMEOUT: %s did not go to %b within %0d cycles", sig, val, limit);
      end
   endtask

   task automatic issue_code(input logic [MC_W-1:0] code);   // one cycle on M21..M18
      m_mcode_i = code;
      @(negedge vm_clk_p);
      m_mcode_i = '0;
   endtask

   // slave side acks after 0 to 7 cycles
   task automatic bus_reply(input string name, input logic vec, input logic exp_we,
                            input logic [DAT_W-1:0] data);
      int dly;
      dly = next_rand() % 8;
      if (vec)
         wait_for("wbi_stb_o", 1'b1, 8);
      else
         wait_for("wbm_stb_o", 1'b1, 8);
      repeat (dly)
      begin
         @(negedge vm_clk_p);
         check_bit({name, " strobe hold"}, 1'b1, vec ? wbi_stb_o : wbm_stb_o);
         check_bit({name, " we hold"}, exp_we, wbm_we_o);
      end
      wbm_dat_i = data;
      wbi_dat_i = data;
      wbm_ack_i = ~vec;
      wbi_ack_i = vec;
      @(negedge vm_clk_p);
      wbm_ack_i = 1'b0;
      wbi_ack_i = 1'b0;
   endtask

   task automatic do_write(input string name, input logic [DAT_W-1:0] addr,
                           input logic [DAT_W-1:0] data, input logic byte_wr);
      logic [1:0] exp_sel;
      exp_sel = byte_wr ? (addr[0] ? 2'b10 : 2'b01) : 2'b11;
      m_syns_i = 1'b1;
      m_astb_i = 1'b1;
      m_ado_i  = addr;
      @(negedge vm_clk_p);
      m_syns_i = 1'b0;
      m_astb_i = 1'b0;
      m_dstb_i = 1'b1;                    // data word follows the address
      m_ado_i  = data;
      @(negedge vm_clk_p);
      m_dstb_i = 1'b0;
      m_do_i   = 1'b1;
      m_wrby_i = byte_wr;
      wait_for("wbm_stb_o", 1'b1, 4);
      check_word({name, " adr"}, addr, wbm_adr_o);
      check_word({name, " dat"}, data, wbm_dat_o);
      check_sel({name, " sel"}, exp_sel, wbm_sel_o);
      bus_reply(name, 1'b0, 1'b1, next_rand());
      wait_for("m_ra_o", 1'b1, 4);
      check_bit({name, " cyc end"}, 1'b0, wbm_cyc_o);
      @(negedge vm_clk_p);
      check_bit({name, " reply 2nd"}, 1'b1, m_ra_o);
      @(negedge vm_clk_p);
      check_bit({name, " reply end"}, 1'b0, m_ra_o);
      m_do_i   = 1'b0;
      m_wrby_i = 1'b0;
   endtask

   task automatic do_read(input string name, input logic [DAT_W-1:0] addr,
                          input logic fast, input logic [3:0] nib);
      logic [DAT_W-1:0] data;
      data = next_rand();
      m_syns_i = 1'b1;
      m_astb_i = 1'b1;
      m_ado_i  = addr;
      @(negedge vm_clk_p);
      m_syns_i = 1'b0;
      m_astb_i = 1'b0;
      m_di_i   = 1'b1;
      if (fast)
         m_mcode_i = MC_SET_FDIN;         // overlay armed inside the cycle
      @(negedge vm_clk_p);
      m_mcode_i = '0;
      check_word({name, " adr"}, addr, wbm_adr_o);
      bus_reply(name, 1'b0, 1'b0, data);
      wait_for("m_ra_o", 1'b1, 4);
      check_word({name, " data"}, fast ? {data[DAT_W-1:4], nib} : data, m_adi_o);
      m_di_i   = 1'b0;
      m_synr_i = 1'b1;                    // chip closes the read
      @(negedge vm_clk_p);
      m_synr_i = 1'b0;
      check_bit({name, " cyc end"}, 1'b0, wbm_cyc_o);
      check_bit({name, " reply cut"}, 1'b0, m_ra_o);
   endtask

   task automatic reset_init();
      repeat (2) @(negedge vm_clk_p);
      check_bit("reset sr", 1'b1, m_sr_o);
      check_bit("reset cyc", 1'b0, wbm_cyc_o);
      check_bit("reset stb", 1'b0, wbm_stb_o);
      check_bit("reset vector stb", 1'b0, wbi_stb_o);
      check_bit("reset reply", 1'b0, m_ra_o);
      check_bit("reset bbusy", 1'b0, m_bbusy_o);
      check_sel("reset sel", 2'b11, wbm_sel_o);
      check_bit("reset init", 1'b1, vm_init_o);
      repeat (2) @(negedge vm_clk_p);
      vm_dclo_i = 1'b0;
      wait_for("m_sr_o", 1'b0, 4);
      check_bit("idle stb", 1'b0, wbm_stb_o);
      check_sel("idle sel", 2'b11, wbm_sel_o);
      check_bit("init held", 1'b1, vm_init_o);
      issue_code(MC_CLR_INIT);
      check_bit("init cleared", 1'b0, vm_init_o);
      issue_code(MC_SET_INIT);
      check_bit("init set again", 1'b1, vm_init_o);
      issue_code(MC_CLR_INIT);            // INIT stays off so berr can set
   endtask

   task automatic write_tests();
      do_write("word write", next_rand() & 16'hfffe, next_rand(), 1'b0);
      do_write("byte write low", next_rand() & 16'hfffe, next_rand(), 1'b1);
      do_write("byte write high", next_rand() | 16'h0001, next_rand(), 1'b1);
   endtask

   task automatic read_tests();
      logic [DAT_W-1:0] vec;
      do_read("word read", next_rand(), 1'b0, 4'h0);
      vec = next_rand() & 16'h01fc;       // vectors sit in low memory
      m_iak_i = 1'b1;
      bus_reply("vector fetch", 1'b1, 1'b0, vec);
      wait_for("m_ra_o", 1'b1, 4);
      check_word("vector fetch data", vec, m_adi_o);
      m_iak_i  = 1'b0;
      m_dclr_i = 1'b1;
      @(negedge vm_clk_p);
      m_dclr_i = 1'b0;
   endtask

   task automatic fast_input();
      do_read("fast read", next_rand(), 1'b1, {1'b0, 1'b0, vm_bsel_i});
      do_read("read after fast", next_rand(), 1'b0, 4'h0);
   endtask

   task automatic bus_timeout();
      m_syns_i = 1'b1;
      m_astb_i = 1'b1;
      m_ado_i  = 16'o160000;              // nothing answers here
      @(negedge vm_clk_p);
      m_syns_i = 1'b0;
      m_astb_i = 1'b0;
      m_di_i   = 1'b1;
      wait_for("wbm_stb_o", 1'b1, 4);
      wait_for("m_sr_o", 1'b1, 70);
      check_bit("timeout stb drop", 1'b0, wbm_stb_o);
      check_bit("timeout cyc drop", 1'b0, wbm_cyc_o);
      m_di_i = 1'b0;
      wait_for("m_sr_o", 1'b0, 4);
      do_read("berr fast read", next_rand(), 1'b1, {1'b0, 1'b1, vm_bsel_i});
      issue_code(MC_CLR_BERR);
      do_read("berr cleared read", next_rand(), 1'b1, {1'b0, 1'b0, vm_bsel_i});
   endtask

   task automatic irq_moderator();
      vm_evnt_i = 1'b1;
      @(negedge vm_clk_p);
      check_bit("evnt request", 1'b1, m_inrrq_o[2]);
      vm_evnt_i = 1'b0;
      @(negedge vm_clk_p);
      check_bit("evnt request held", 1'b1, m_inrrq_o[2]);
      issue_code(MC_CLR_EVNT);
      check_bit("evnt request cleared", 1'b0, m_inrrq_o[2]);
      vm_aclo_i = 1'b1;
      @(negedge vm_clk_p);
      check_bit("aclo request", 1'b1, m_inrrq_o[3]);
      vm_aclo_i = 1'b0;
      @(negedge vm_clk_p);
      check_bit("aclo request held", 1'b1, m_inrrq_o[3]);
      issue_code(MC_CLR_ACLO);
      check_bit("aclo request cleared", 1'b0, m_inrrq_o[3]);
      vm_virq_i = 1'b1;
      @(negedge vm_clk_p);
      check_bit("virq passes", 1'b1, m_inrrq_o[1]);
      vm_virq_i = 1'b0;
      @(negedge vm_clk_p);
      check_bit("virq released", 1'b0, m_inrrq_o[1]);
      vm_clk_slow_i = 1'b1;               // slow mode with no enables yet
      vm_clk_ena_i  = 1'b0;
      wait_for("m_bbusy_o", 1'b1, 4);
      repeat (6) @(negedge vm_clk_p);
      check_bit("bbusy held", 1'b1, m_bbusy_o);
      m_breq_i = 1'b1;
      @(negedge vm_clk_p);
      check_bit("bbusy waits for enables", 1'b1, m_bbusy_o);
      vm_clk_ena_i = 1'b1;                // pay back the owed enables
      wait_for("m_bbusy_o", 1'b0, 20);
      m_breq_i     = 1'b0;
      vm_clk_ena_i = 1'b0;
      wait_for("m_bbusy_o", 1'b1, 4);
      vm_clk_slow_i = 1'b0;               // mode off drops busy at once
      vm_clk_ena_i  = 1'b1;
      @(negedge vm_clk_p);
      check_bit("bbusy slow off", 1'b0, m_bbusy_o);
   endtask

   initial
   begin
      vm_dclo_i = 1'b1;
      vm_aclo_i = 1'b0;
      vm_halt_i = 1'b0;
      vm_evnt_i = 1'b0;
      vm_virq_i = 1'b0;
      vm_clk_ena_i  = 1'b1;
      vm_clk_slow_i = 1'b0;
      vm_bsel_i = 2'b10;                  // boot select seen in the overlay
      m_syns_i  = 1'b0;
      m_synr_i  = 1'b0;
      m_dclr_i  = 1'b0;
      m_di_i    = 1'b0;
      m_do_i    = 1'b0;
      m_iak_i   = 1'b0;
      m_wrby_i  = 1'b0;
      m_breq_i  = 1'b0;
      m_astb_i  = 1'b0;
      m_dstb_i  = 1'b0;
      m_ado_i   = '0;
      m_mcode_i = '0;
      wbm_gnt_i = 1'b1;                   // bus always granted
      wbm_dat_i = '0;
      wbm_ack_i = 1'b0;
      wbi_dat_i = '0;
      wbi_ack_i = 1'b0;
      reset_init();
      write_tests();
      read_tests();
      fast_input();
      bus_timeout();
      irq_moderator();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* build.f */
verilog/lsi_bus_pkg.sv
verilog/lsi_wb_master.sv
verilog/lsi_bus_moderator.sv
verilog/lsi_sys_ctl.sv
verilog/lsi_wb.sv
test/lsi_wb_assert.sv
test/tb_lsi_wb.sv

/* run.sh */
#!/bin/sh
# compile and run the lsi-11 bus glue testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_lsi_wb
if ./obj_dir/Vtb_lsi_wb | tee /dev/stderr | grep -x "Everything OK" > /dev/null
then
   echo "simulation passed"
   exit 0
else
   echo "simulation did not pass"
   exit 1
fi
